/* source/core_mem_config.svh */
`ifndef CORE_MEM_CONFIG_SVH
`define CORE_MEM_CONFIG_SVH

// bus widths.
`define CM_ADDR_W 32
`define CM_DATA_W 32

// instruction cache lines, one word each.
`define CM_ICACHE_LINES 16

// CLINT window, 64 KiB.
`define CM_CLINT_BASE (32'h0200_0000)
`define CM_CLINT_MASK (32'hFFFF_0000)

`endif

/* source/core_mem_pkg.sv */
`include "core_mem_config.svh"

package core_mem_pkg;

	// one single-beat bus request.
	typedef struct packed {
		logic [`CM_ADDR_W-1:0]   addr;
		logic [`CM_DATA_W-1:0]   wdata;
		logic [`CM_DATA_W/8-1:0] wstrb;
		logic                    write;
		logic                    instr; // set by the fetch port.
	} bus_req_t;

	// read data only, there is no error response.
	typedef struct packed {
		logic [`CM_DATA_W-1:0] rdata;
	} bus_rsp_t;

	// load/store operation from the execute stage.
	typedef struct packed {
		logic [`CM_ADDR_W-1:0] addr;
		logic [`CM_DATA_W-1:0] wdata;
		logic [2:0]            funct3; // [1:0] size, [2] unsigned.
		logic                  write;
	} ls_op_t;

endpackage

/* source/fetch_port.sv */
`timescale 1ns/1ps
`include "core_mem_config.svh"

module fetch_port
	import core_mem_pkg::*;
#(
	parameter int lines = `CM_ICACHE_LINES
) (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  fetch_valid,
	output logic                  fetch_ready,
	input  logic [`CM_ADDR_W-1:0] fetch_pc,
	input  logic                  fence_i,
	output logic                  inst_valid,
	output logic [`CM_DATA_W-1:0] inst,
	output logic                  req_valid,
	input  logic                  req_ready,
	output bus_req_t              req,
	input  logic                  rsp_valid,
	input  bus_rsp_t              rsp
);

	localparam int idx_w = $clog2(lines);
	localparam int tag_w = `CM_ADDR_W - 2 - idx_w;

	typedef enum logic [1:0] {s_boot, s_idle, s_req, s_wait} state_t;

	state_t                state;
	logic [`CM_ADDR_W-1:0] pc_q;
	logic [lines-1:0]      line_valid;
	logic [tag_w-1:0]      line_tag [lines];
	logic [`CM_DATA_W-1:0] line_data [lines];
	logic [idx_w-1:0]      acc_idx;
	logic [idx_w-1:0]      fill_idx;
	logic [tag_w-1:0]      acc_tag;
	logic                  accept;
	logic                  hit;
	logic                  fence_now;
	logic                  fill;

	assign fetch_ready = (state == s_idle);
	assign accept      = fetch_valid && fetch_ready;
	assign fence_now   = fence_i && (state == s_idle); // ignored while a miss is open.
	assign acc_idx     = fetch_pc[idx_w+1:2];
	assign acc_tag     = fetch_pc[`CM_ADDR_W-1:idx_w+2];
	assign fill_idx    = pc_q[idx_w+1:2];
	assign fill        = (state == s_wait) && rsp_valid;

	// a fetch on the fence cycle must not hit a line that is being dropped.
	assign hit = line_valid[acc_idx] && (line_tag[acc_idx] == acc_tag) && !fence_now;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state      <= s_boot;
			line_valid <= '0;
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= (accept && hit) || fill;
			if (fence_now) begin
				line_valid <= '0;
			end else if (fill) begin
				line_valid[fill_idx] <= 1'b1;
			end
			case (state)
				s_boot: begin
					state <= s_idle;
				end
				s_idle: begin
					if (accept && !hit) begin
						state <= s_req;
					end
				end
				s_req: begin
					if (req_ready) begin
						state <= s_wait;
					end
				end
				s_wait: begin
					if (rsp_valid) begin
						state <= s_idle;
					end
				end
				default: begin
					state <= s_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			pc_q <= fetch_pc;
			inst <= line_data[acc_idx]; // only shown on a hit.
		end else if (fill) begin
			inst <= rsp.rdata;
		end
		if (fill) begin
			line_tag[fill_idx]  <= pc_q[`CM_ADDR_W-1:idx_w+2];
			line_data[fill_idx] <= rsp.rdata;
		end
	end

	always_comb begin
		req       = '0;
		req.addr  = pc_q;
		req.instr = 1'b1;
	end

	assign req_valid = (state == s_req);

	a_fetch_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		accept |-> fetch_pc[1:0] == 2'b00);

endmodule

/* source/load_store_port.sv */
`timescale 1ns/1ps
`include "core_mem_config.svh"

module load_store_port
	import core_mem_pkg::*;
(
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  ls_valid,
	output logic                  ls_ready,
	input  ls_op_t                ls_op,
	output logic                  ls_done,
	output logic [`CM_DATA_W-1:0] load_data,
	output logic                  req_valid,
	input  logic                  req_ready,
	output bus_req_t              req,
	input  logic                  rsp_valid,
	input  bus_rsp_t              rsp
);

	typedef enum logic [1:0] {s_boot, s_idle, s_req, s_wait} state_t;

	state_t                  state;
	bus_req_t                req_q;
	logic [1:0]              off_q;
	logic [2:0]              funct3_q;
	logic                    accept;
	logic                    rsp_take;
	logic [`CM_DATA_W/8-1:0] strb;
	logic [`CM_DATA_W-1:0]   wdata_rep;
	logic [`CM_DATA_W-1:0]   lane;
	logic [`CM_DATA_W-1:0]   ext;

	assign ls_ready  = (state == s_idle);
	assign accept    = ls_valid && ls_ready;
	assign rsp_take  = (state == s_wait) && rsp_valid;
	assign req_valid = (state == s_req);
	assign req       = req_q;

	// store lanes from size and byte offset.
	always_comb begin
		case (ls_op.funct3[1:0])
			2'b00: begin
				strb      = 4'b0001 << ls_op.addr[1:0];
				wdata_rep = {4{ls_op.wdata[7:0]}};
			end
			2'b01: begin
				strb      = 4'b0011 << ls_op.addr[1:0];
				wdata_rep = {2{ls_op.wdata[15:0]}};
			end
			default: begin
				strb      = 4'b1111;
				wdata_rep = ls_op.wdata;
			end
		endcase
	end

	// shift the addressed lane down, then extend.
	always_comb begin
		lane = rsp.rdata >> {off_q, 3'b000};
		case (funct3_q[1:0])
			2'b00: ext = {{(`CM_DATA_W-8){~funct3_q[2] & lane[7]}}, lane[7:0]};
			2'b01: ext = {{(`CM_DATA_W-16){~funct3_q[2] & lane[15]}}, lane[15:0]};
			default: ext = lane;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state   <= s_boot;
			ls_done <= 1'b0;
		end else begin
			ls_done <= rsp_take;
			case (state)
				s_boot: begin
					state <= s_idle;
				end
				s_idle: begin
					if (accept) begin
						state <= s_req;
					end
				end
				s_req: begin
					if (req_ready) begin
						state <= s_wait;
					end
				end
				s_wait: begin
					if (rsp_valid) begin
						state <= s_idle;
					end
				end
				default: begin
					state <= s_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			req_q.addr  <= {ls_op.addr[`CM_ADDR_W-1:2], 2'b00};
			req_q.wdata <= wdata_rep;
			req_q.wstrb <= ls_op.write ? strb : '0;
			req_q.write <= ls_op.write;
			req_q.instr <= 1'b0;
			off_q       <= ls_op.addr[1:0];
			funct3_q    <= ls_op.funct3;
		end
		if (rsp_take) begin
			load_data <= req_q.write ? '0 : ext;
		end
	end

	a_ls_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		accept |-> (ls_op.funct3[1:0] != 2'b01 || !ls_op.addr[0]) &&
			(ls_op.funct3[1:0] != 2'b10 || ls_op.addr[1:0] == 2'b00));

endmodule

/* source/bus_xbar.sv */
`timescale 1ns/1ps
`include "core_mem_config.svh"

module bus_xbar
	import core_mem_pkg::*;
(
	input  logic     clock,
	input  logic     rst_n,
	input  logic     fetch_req_valid,
	output logic     fetch_req_ready,
	input  bus_req_t fetch_req,
	output logic     fetch_rsp_valid,
	input  logic     ls_req_valid,
	output logic     ls_req_ready,
	input  bus_req_t ls_req,
	output logic     ls_rsp_valid,
	output bus_rsp_t rsp,
	output logic     mem_req_valid,
	input  logic     mem_req_ready,
	output bus_req_t mem_req,
	input  logic     mem_rsp_valid,
	input  bus_rsp_t mem_rsp,
	output logic     timer_req_valid,
	output bus_req_t timer_req,
	input  logic     timer_rsp_valid,
	input  bus_rsp_t timer_rsp
);

	typedef enum logic [1:0] {g_idle, g_ifu, g_lsu} grant_t;

	grant_t                grant;
	logic                  sent;        // request taken by the target.
	logic                  to_timer;
	logic                  owner_instr;
	bus_req_t              sel_req;
	logic [`CM_ADDR_W-1:0] win_addr;
	logic                  win_instr;
	logic                  win_clint;
	logic                  granted;
	logic                  issue_ok;
	logic                  rsp_hit;

	// load-store port has fixed priority.
	assign win_addr  = ls_req_valid ? ls_req.addr : fetch_req.addr;
	assign win_instr = ls_req_valid ? ls_req.instr : fetch_req.instr;
	assign win_clint = (win_addr & `CM_CLINT_MASK) == `CM_CLINT_BASE;

	assign sel_req  = (grant == g_lsu) ? ls_req : fetch_req;
	assign granted  = (grant != g_idle);
	assign issue_ok = granted && !sent && (to_timer || mem_req_ready); // timer never stalls.

	assign mem_req_valid   = granted && !sent && !to_timer;
	assign mem_req         = sel_req;
	assign timer_req_valid = granted && !sent && to_timer;
	assign timer_req       = sel_req;

	assign fetch_req_ready = issue_ok && (grant == g_ifu);
	assign ls_req_ready    = issue_ok && (grant == g_lsu);

	assign rsp_hit         = sent && (to_timer ? timer_rsp_valid : mem_rsp_valid);
	assign fetch_rsp_valid = rsp_hit && (grant == g_ifu);
	assign ls_rsp_valid    = rsp_hit && (grant == g_lsu);
	assign rsp             = to_timer ? timer_rsp : mem_rsp;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			grant       <= g_idle;
			sent        <= 1'b0;
			to_timer    <= 1'b0;
			owner_instr <= 1'b0;
		end else begin
			case (grant)
				g_idle: begin
					if (ls_req_valid || fetch_req_valid) begin
						grant       <= ls_req_valid ? g_lsu : g_ifu;
						to_timer    <= win_clint;
						owner_instr <= win_instr;
					end
				end
				default: begin
					if (issue_ok) begin
						sent <= 1'b1;
					end
					if (rsp_hit) begin
						grant <= g_idle; // one transfer per grant.
						sent  <= 1'b0;
					end
				end
			endcase
		end
	end

	a_mem_rsp_requested: assert property (@(posedge clock) disable iff (!rst_n)
		mem_rsp_valid |-> sent && !to_timer);

	a_timer_rsp_requested: assert property (@(posedge clock) disable iff (!rst_n)
		timer_rsp_valid |-> sent && to_timer);

	// the instr bit set at the source must match the port that gets the data.
	a_rsp_owner: assert property (@(posedge clock) disable iff (!rst_n)
		(fetch_rsp_valid || ls_rsp_valid) |-> owner_instr == fetch_rsp_valid);

endmodule

/* source/clint_timer.sv */
`timescale 1ns/1ps
`include "core_mem_config.svh"

module clint_timer
	import core_mem_pkg::*;
(
	input  logic     clock,
	input  logic     rst_n,
	input  logic     req_valid,
	input  bus_req_t req,
	output logic     rsp_valid,
	output bus_rsp_t rsp
);

	localparam logic [`CM_ADDR_W-1:0] mtime_lo = 32'h0000_BFF8;
	localparam logic [`CM_ADDR_W-1:0] mtime_hi = 32'h0000_BFFC;

	logic [63:0]           mtime;
	logic [`CM_ADDR_W-1:0] offset;

	assign offset = req.addr & ~`CM_CLINT_MASK;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mtime     <= '0;
			rsp_valid <= 1'b0;
		end else begin
			mtime     <= mtime + 64'd1;
			rsp_valid <= req_valid; // writes get a response too.
		end
	end

	always_ff @(posedge clock) begin
		if (req_valid) begin
			if (req.write) begin
				rsp.rdata <= '0; // mtime is read-only.
			end else if (offset == mtime_lo) begin
				rsp.rdata <= mtime[31:0];
			end else if (offset == mtime_hi) begin
				rsp.rdata <= mtime[63:32];
			end else begin
				rsp.rdata <= '0;
			end
		end
	end

endmodule

/* source/core_mem_top.sv */
`timescale 1ns/1ps
`include "core_mem_config.svh"

module core_mem_top
	import core_mem_pkg::*;
(
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  fetch_valid,
	output logic                  fetch_ready,
	input  logic [`CM_ADDR_W-1:0] fetch_pc,
	output logic                  inst_valid,
	output logic [`CM_DATA_W-1:0] inst,
	input  logic                  fence_i,
	input  logic                  ls_valid,
	output logic                  ls_ready,
	input  ls_op_t                ls_op,
	output logic                  ls_done,
	output logic [`CM_DATA_W-1:0] load_data,
	output logic                  mem_req_valid,
	input  logic                  mem_req_ready,
	output bus_req_t              mem_req,
	input  logic                  mem_rsp_valid,
	input  bus_rsp_t              mem_rsp
);

	logic     fetch_req_valid;
	logic     fetch_req_ready;
	bus_req_t fetch_req;
	logic     fetch_rsp_valid;
	logic     ls_req_valid;
	logic     ls_req_ready;
	bus_req_t ls_req;
	logic     ls_rsp_valid;
	bus_rsp_t xbar_rsp;  // shared by both ports.
	logic     timer_req_valid;
	bus_req_t timer_req;
	logic     timer_rsp_valid;
	bus_rsp_t timer_rsp;

	fetch_port fetch0 (
		.clock(clock),
		.rst_n(rst_n),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.fetch_pc(fetch_pc),
		.fence_i(fence_i),
		.inst_valid(inst_valid),
		.inst(inst),
		.req_valid(fetch_req_valid),
		.req_ready(fetch_req_ready),
		.req(fetch_req),
		.rsp_valid(fetch_rsp_valid),
		.rsp(xbar_rsp)
	);

	load_store_port lsu0 (
		.clock(clock),
		.rst_n(rst_n),
		.ls_valid(ls_valid),
		.ls_ready(ls_ready),
		.ls_op(ls_op),
		.ls_done(ls_done),
		.load_data(load_data),
		.req_valid(ls_req_valid),
		.req_ready(ls_req_ready),
		.req(ls_req),
		.rsp_valid(ls_rsp_valid),
		.rsp(xbar_rsp)
	);

	bus_xbar xbar0 (
		.clock(clock),
		.rst_n(rst_n),
		.fetch_req_valid(fetch_req_valid),
		.fetch_req_ready(fetch_req_ready),
		.fetch_req(fetch_req),
		.fetch_rsp_valid(fetch_rsp_valid),
		.ls_req_valid(ls_req_valid),
		.ls_req_ready(ls_req_ready),
		.ls_req(ls_req),
		.ls_rsp_valid(ls_rsp_valid),
		.rsp(xbar_rsp),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req(mem_req),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp(mem_rsp),
		.timer_req_valid(timer_req_valid),
		.timer_req(timer_req),
		.timer_rsp_valid(timer_rsp_valid),
		.timer_rsp(timer_rsp)
	);

	clint_timer timer0 (
		.clock(clock),
		.rst_n(rst_n),
		.req_valid(timer_req_valid),
		.req(timer_req),
		.rsp_valid(timer_rsp_valid),
		.rsp(timer_rsp)
	);

endmodule

/* testbench/core_mem_tb.sv */
`timescale 1ns/1ps

module core_mem_tb
	import core_mem_pkg::*;
();

	typedef struct packed {
		logic [2:0]  f3;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp_val;
	} test_line_t;

	logic        clock;
	logic        rst_n;
	logic        fetch_valid;
	logic        fetch_ready;
	logic [31:0] fetch_pc;
	logic        inst_valid;
	logic [31:0] inst;
	logic        fence_i;
	logic        ls_valid;
	logic        ls_ready;
	ls_op_t      ls_op;
	logic        ls_done;
	logic [31:0] load_data;
	logic        mem_req_valid;
	logic        mem_req_ready;
	bus_req_t    mem_req;
	logic        mem_rsp_valid;
	bus_rsp_t    mem_rsp;

	logic [31:0] mem [logic [29:0]];
	logic        take_log [$];   // instr bit of every accepted mem request.
	int          mem_valid_cycles;
	integer      seed = 68;
	int          checks;
	int          errors;
	int          limit;
	int          cycle_count;
	logic [31:0] last_timer;
	string       ops [$];
	test_line_t  lines [$];
	int          line_nos [$];

	core_mem_top dut0 (
		.clock(clock),
		.rst_n(rst_n),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.fetch_pc(fetch_pc),
		.inst_valid(inst_valid),
		.inst(inst),
		.fence_i(fence_i),
		.ls_valid(ls_valid),
		.ls_ready(ls_ready),
		.ls_op(ls_op),
		.ls_done(ls_done),
		.load_data(load_data),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req(mem_req),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp(mem_rsp)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] read_word(input logic [29:0] w);
		if (mem.exists(w)) begin
			return mem[w];
		end
		return {w, 2'b00} ^ 32'h5A5A_A5A5; // unwritten words differ by address.
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] strb);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return res;
	endfunction

	// external memory with random stall and 1 to 4 cycle response delay.
	initial begin : memory_model
		logic        take;
		bus_req_t    req_q;
		int          countdown;
		logic [29:0] w;
		mem_req_ready    = 1'b0;
		mem_rsp_valid    = 1'b0;
		mem_rsp          = '0;
		mem_valid_cycles = 0;
		countdown        = 0;
		forever begin
			@(negedge clock);
			take  = mem_req_valid && mem_req_ready; // transfer at the coming edge.
			req_q = mem_req;
			if (mem_req_valid) begin
				mem_valid_cycles++;
			end
			if (take) begin
				take_log.push_back(req_q.instr);
			end
			@(posedge clock);
			#2;
			mem_rsp_valid = 1'b0;
			if (take) begin
				w = req_q.addr[31:2];
				if (req_q.write) begin
					mem[w] = merge_bytes(read_word(w), req_q.wdata, req_q.wstrb);
					mem_rsp.rdata = '0;
				end else begin
					mem_rsp.rdata = read_word(w);
				end
				countdown = 1 + int'($unsigned($random(seed)) % 4);
			end
			if (countdown > 0) begin
				countdown--;
				mem_rsp_valid = (countdown == 0);
			end
			mem_req_ready = ($unsigned($random(seed)) % 4) != 0;
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (limit == 0 || cycle_count <= limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d cycles", limit);
		$display("Result: FAILED");
		$finish;
	end

	task automatic step();
		@(posedge clock);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp_val,
			input logic [31:0] act);
		checks++;
		assert (act === exp_val) else begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp_val, act);
			errors++;
		end
	endtask

	task automatic check_true(input string name, input logic cond, input string what);
		checks++;
		assert (cond) else begin
			$display("%s: %s", name, what);
			errors++;
		end
	endtask

	task automatic run_fetch(input string name, input test_line_t t);
		int lat;
		int vcount;
		while (!fetch_ready) begin
			step();
		end
		vcount = mem_valid_cycles;
		take_log.delete();
		fetch_valid = 1'b1;
		fetch_pc    = t.addr;
		step();
		fetch_valid = 1'b0;
		lat = 1;
		while (!inst_valid) begin
			step();
			lat++;
		end
		check_value(name, t.exp_val, inst);
		if (t.data == 32'd1) begin
			check_true(name, lat == 1, "cache hit did not answer in one cycle");
			check_true(name, mem_valid_cycles == vcount, "cache hit raised mem_req_valid");
		end else if (t.data == 32'd2) begin
			check_true(name, take_log.size() > 0 && take_log[0], "cache miss made no bus read");
		end
	endtask

	task automatic run_ls(input logic write, input test_line_t t, output logic [31:0] result);
		while (!ls_ready) begin
			step();
		end
		ls_op.addr   = t.addr;
		ls_op.wdata  = t.data;
		ls_op.funct3 = t.f3;
		ls_op.write  = write;
		ls_valid     = 1'b1;
		step();
		ls_valid = 1'b0;
		while (!ls_done) begin
			step();
		end
		result = load_data;
	endtask

	task automatic run_timer(input string name, input test_line_t t);
		int          vcount;
		logic [31:0] result;
		vcount = mem_valid_cycles;
		run_ls(1'b0, t, result);
		check_true(name, mem_valid_cycles == vcount, "timer read reached the external bus");
		checks++;
		assert (result > last_timer) else begin
			$display("CHECK FAILED %s expected above %h actual %h", name, last_timer, result);
			errors++;
		end
		last_timer = result;
	endtask

	task automatic pulse_fence();
		while (!fetch_ready) begin
			step();
		end
		fence_i = 1'b1;
		step();
		fence_i = 1'b0;
	endtask

	// fetch and load of the same word on one cycle.
	task automatic run_dual(input string name, input test_line_t t);
		logic        got_i;
		logic        got_l;
		logic [31:0] inst_v;
		logic [31:0] load_v;
		got_i  = 1'b0;
		got_l  = 1'b0;
		inst_v = '0;
		load_v = '0;
		while (!(fetch_ready && ls_ready)) begin
			step();
		end
		take_log.delete();
		fetch_pc     = t.addr;
		fetch_valid  = 1'b1;
		ls_op.addr   = t.addr;
		ls_op.wdata  = '0;
		ls_op.funct3 = t.f3;
		ls_op.write  = 1'b0;
		ls_valid     = 1'b1;
		step();
		fetch_valid = 1'b0;
		ls_valid    = 1'b0;
		while (!(got_i && got_l)) begin
			if (inst_valid) begin
				got_i  = 1'b1;
				inst_v = inst;
			end
			if (ls_done) begin
				got_l  = 1'b1;
				load_v = load_data;
			end
			step();
		end
		check_value({name, " fetch"}, t.exp_val, inst_v);
		check_value({name, " load"}, t.exp_val, load_v);
		check_true(name, take_log.size() >= 2 && !take_log[0], "load was not first on the bus");
	endtask

	initial begin : main
		integer      fd;
		int          n;
		int          file_lines;
		string       text;
		string       op;
		logic [31:0] f3_in;
		logic [31:0] addr_in;
		logic [31:0] data_in;
		logic [31:0] exp_in;
		test_line_t  t;
		logic [31:0] result;
		string       name;
		rst_n       = 1'b0;
		fetch_valid = 1'b0;
		fetch_pc    = '0;
		fence_i     = 1'b0;
		ls_valid    = 1'b0;
		ls_op       = '0;
		checks      = 0;
		errors      = 0;
		limit       = 0;
		last_timer  = '0;
		file_lines  = 0;
		fd = $fopen("testbench/core_mem_input.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/core_mem_input.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				text = "";
				n = $fgets(text, fd);
				file_lines++;
				if (text.len() > 1 && text.getc(0) != "#") begin
					n = $sscanf(text, "%s %h %h %h %h", op, f3_in, addr_in, data_in, exp_in);
					if (n == 5) begin
						t.f3      = f3_in[2:0];
						t.addr    = addr_in;
						t.data    = data_in;
						t.exp_val = exp_in;
						ops.push_back(op);
						lines.push_back(t);
						line_nos.push_back(file_lines);
					end else begin
						$display("input line %0d could not be parsed", file_lines);
						errors++;
					end
				end
			end
			$fclose(fd);
			limit = 40 * file_lines + 10; // reset cycles on top.
		end
		repeat (10) @(posedge clock);
		#2;
		check_true("reset",
			!(fetch_ready || ls_ready || inst_valid || ls_done || mem_req_valid),
			"an output was high during reset");
		rst_n = 1'b1;
		check_true("reset", !(fetch_ready || ls_ready), "a ready rose with the reset release");
		step();
		check_true("reset", fetch_ready && ls_ready,
			"the ready outputs did not rise one cycle after reset");
		for (int i = 0; i < ops.size(); i++) begin
			t    = lines[i];
			name = $sformatf("line %0d %s %h", line_nos[i], ops[i], t.addr);
			if (ops[i] == "preload") begin
				mem[t.addr[31:2]] = t.data;
			end else if (ops[i] == "fetch") begin
				run_fetch(name, t);
			end else if (ops[i] == "load" || ops[i] == "store") begin
				run_ls(ops[i] == "store", t, result);
				check_value(name, t.exp_val, result);
			end else if (ops[i] == "fence") begin
				pulse_fence();
			end else if (ops[i] == "timer") begin
				run_timer(name, t);
			end else if (ops[i] == "dual") begin
				run_dual(name, t);
			end else begin
				$display("%s: unknown operation in the input file", name);
				errors++;
			end
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* testbench/core_mem_input.txt */
# columns: op funct3 address data expected, all hex, one operation per line
# fetch data: 1 must hit, 2 must miss, 0 either. dual: fetch and load one word together
preload 0 00001000 00000013 00000000
preload 0 00001004 00a00093 00000000
preload 0 00001008 00108113 00000000
preload 0 00001040 deadbeef 00000000
preload 0 00002000 11223344 00000000
preload 0 00002004 8899aabb 00000000
preload 0 00002008 f0e1d2c3 00000000
fetch 0 00001000 00000002 00000013
fetch 0 00001000 00000001 00000013
fetch 0 00001004 00000002 00a00093
fetch 0 00001004 00000001 00a00093
load 0 00002004 00000000 ffffffbb
load 0 00002005 00000000 ffffffaa
load 0 00002006 00000000 ffffff99
load 0 00002007 00000000 ffffff88
load 4 00002004 00000000 000000bb
load 4 00002005 00000000 000000aa
load 4 00002006 00000000 00000099
load 4 00002007 00000000 00000088
load 1 00002004 00000000 ffffaabb
load 1 00002006 00000000 ffff8899
load 5 00002004 00000000 0000aabb
load 5 00002006 00000000 00008899
load 2 00002004 00000000 8899aabb
load 0 00002000 00000000 00000044
load 1 00002002 00000000 00001122
store 0 00002009 0000005a 00000000
store 1 0000200a 00007788 00000000
load 2 00002008 00000000 77885ac3
store 0 00002003 000000ee 00000000
store 1 00002000 0000abcd 00000000
load 2 00002000 00000000 ee22abcd
load 4 00002003 00000000 000000ee
store 2 0000200c 01020304 00000000
load 2 0000200c 00000000 01020304
fetch 0 00001008 00000002 00108113
fetch 0 00001008 00000001 00108113
store 2 00001008 00200193 00000000
fetch 0 00001008 00000001 00108113
fence 0 00000000 00000000 00000000
fetch 0 00001008 00000002 00200193
timer 2 0200bff8 00000000 00000000
timer 2 0200bff8 00000000 00000000
load 2 0200bffc 00000000 00000000
dual 2 00001040 00000000 deadbeef
fetch 0 00001040 00000001 deadbeef
fetch 0 00001000 00000002 00000013

/* build.f */
+incdir+source
source/core_mem_pkg.sv
source/fetch_port.sv
source/load_store_port.sv
source/bus_xbar.sv
source/clint_timer.sv
source/core_mem_top.sv
testbench/core_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = core_mem_tb
RTL_TOP   = core_mem_top
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
